/* verilog/muldiv_consts.svh */
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// ----------------------------------------
// Datapath width
// ----------------------------------------

// Operand and result width for RV32
`define MD_XLEN 32

// ----------------------------------------
// Divider iteration count
// ----------------------------------------

// One quotient bit per DIVIDE cycle
`define MD_DIV_STEPS `MD_XLEN

`endif

/* verilog/muldiv_pkg.sv */
package muldiv_pkg;

    // ----------------------------------------
    // M extension operations
    // ----------------------------------------
    // Bit 2 picks the divider and the low two bits give the sub-op
    typedef enum logic [3:0] {
        MUL    = 4'd0,  // Low word of product
        MULH   = 4'd1,  // High word, signed x signed
        MULHSU = 4'd2,  // High word, signed x unsigned
        MULHU  = 4'd3,  // High word, unsigned x unsigned
        DIV    = 4'd4,
        DIVU   = 4'd5,
        REM    = 4'd6,
        REMU   = 4'd7
    } md_op_t;

    // ----------------------------------------
    // Divider FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        INIT,    // Signs and magnitudes
        DIVIDE,  // Shift-subtract loop
        DONE     // Result cycle
    } div_state_t;

endpackage

/* verilog/int_divider.sv */
`timescale 1ns/1ns

`include "muldiv_consts.svh"

module int_divider import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [1:0]          div_op,       // 00 DIV, 01 DIVU, 10 REM, 11 REMU
    input  logic [`MD_XLEN-1:0] numerator,
    input  logic [`MD_XLEN-1:0] denominator,
    output logic [`MD_XLEN-1:0] result,
    output logic                division_done,
    output logic                div_busy
);

    localparam int CNT_W = $clog2(`MD_DIV_STEPS + 1);

    div_state_t state, next_state;

    // Operands captured at start
    logic [`MD_XLEN-1:0] num_q;
    logic [`MD_XLEN-1:0] den_q;
    logic [1:0]          op_q;
    md_op_t              op_full;

    // ----------------------------------------
    // Working registers
    // ----------------------------------------
    logic [`MD_XLEN-1:0] rem;      // Always below the divisor
    logic [`MD_XLEN-1:0] quo;
    logic [`MD_XLEN-1:0] den;
    logic [CNT_W-1:0]    counter;

    logic sign_q;          // Quotient negative
    logic sign_r;          // Remainder follows numerator
    logic div_zero;
    logic overflow;        // Most negative / -1
    logic is_signed;
    logic last_step;

    logic [`MD_XLEN:0]   rem_shift;
    logic [`MD_XLEN-1:0] rem_step;
    logic [`MD_XLEN-1:0] quo_step;
    logic [`MD_XLEN-1:0] final_word;

    assign op_full   = md_op_t'({2'b01, op_q});
    assign is_signed = (op_full == DIV) || (op_full == REM);
    assign last_step = (counter == CNT_W'(`MD_DIV_STEPS - 1));
    assign div_busy  = (state != IDLE);

    // One restoring step
    always_comb begin
        rem_shift = {rem, quo[`MD_XLEN-1]};
        quo_step  = {quo[`MD_XLEN-2:0], 1'b0};
        rem_step  = rem_shift[`MD_XLEN-1:0];
        if (rem_shift >= {1'b0, den}) begin
            rem_step    = rem_shift[`MD_XLEN-1:0] - den;
            quo_step[0] = 1'b1;
        end
    end

    // Sign fix and the architectural corner cases
    always_comb begin
        case (op_full)
            DIV: begin
                if (div_zero)
                    final_word = '1;
                else if (overflow)
                    final_word = num_q;
                else
                    final_word = sign_q ? -quo_step : quo_step;
            end
            REM: begin
                if (div_zero)
                    final_word = num_q;
                else if (overflow)
                    final_word = '0;
                else
                    final_word = sign_r ? -rem_step : rem_step;
            end
            REMU:    final_word = div_zero ? num_q : rem_step;
            default: final_word = div_zero ? '1 : quo_step;  // DIVU
        endcase
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start) next_state = INIT;
            INIT:    next_state = DIVIDE;
            DIVIDE:  if (last_step) next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    // Control and result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            counter       <= '0;
            division_done <= 1'b0;
            result        <= '0;
        end else begin
            state         <= next_state;
            division_done <= 1'b0;
            case (state)
                INIT: counter <= '0;
                DIVIDE: begin
                    counter <= counter + 1'b1;
                    if (last_step) begin
                        division_done <= 1'b1;   // High through DONE
                        result        <= final_word;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    num_q <= numerator;
                    den_q <= denominator;
                    op_q  <= div_op;
                end
            end
            INIT: begin
                rem      <= '0;
                div_zero <= (den_q == '0);
                overflow <= is_signed && (den_q == '1) &&
                            (num_q == {1'b1, {(`MD_XLEN-1){1'b0}}});
                if (is_signed) begin
                    sign_q <= num_q[`MD_XLEN-1] ^ den_q[`MD_XLEN-1];
                    sign_r <= num_q[`MD_XLEN-1];
                    quo    <= num_q[`MD_XLEN-1] ? -num_q : num_q;
                    den    <= den_q[`MD_XLEN-1] ? -den_q : den_q;
                end else begin
                    sign_q <= 1'b0;
                    sign_r <= 1'b0;
                    quo    <= num_q;
                    den    <= den_q;
                end
            end
            DIVIDE: begin
                rem <= rem_step;
                quo <= quo_step;
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        div_busy |-> !start);

    // Loop runs one cycle per quotient bit
    a_divide_len: assert property (@(posedge clk) disable iff (!rst_n)
        (state == INIT) |=> (state == DIVIDE) [*`MD_DIV_STEPS] ##1 (state == DONE));

endmodule

/* verilog/int_multiplier.sv */
`timescale 1ns/1ns

`include "muldiv_consts.svh"

module int_multiplier import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [1:0]          mul_op,
    input  logic [`MD_XLEN-1:0] multiplicand,
    input  logic [`MD_XLEN-1:0] multiplier,
    output logic [`MD_XLEN-1:0] result,
    output logic                mul_done,
    output logic                mul_busy
);

    md_op_t op_in;
    logic   a_sext;            // Extend multiplicand by sign
    logic   b_sext;            // Extend multiplier by sign

    // ----------------------------------------
    // Stage one registers
    // ----------------------------------------
    logic signed [`MD_XLEN:0] a_s1;
    logic signed [`MD_XLEN:0] b_s1;
    md_op_t                   op_s1;
    logic                     v_s1;

    logic signed [2*`MD_XLEN+1:0] product;
    logic [`MD_XLEN-1:0]          prod_word;

    assign op_in  = md_op_t'({2'b00, mul_op});
    assign a_sext = (op_in != MULHU);
    assign b_sext = (op_in == MUL) || (op_in == MULH);

    // Operands captured and extended to 33 bits
    always_ff @(posedge clk) begin
        if (start) begin
            a_s1  <= {a_sext & multiplicand[`MD_XLEN-1], multiplicand};
            b_s1  <= {b_sext & multiplier[`MD_XLEN-1], multiplier};
            op_s1 <= op_in;
        end
    end

    // Full signed product of the extended operands
    assign product = a_s1 * b_s1;

    // Low word only for MUL
    assign prod_word = (op_s1 == MUL) ? product[`MD_XLEN-1:0]
                                      : product[2*`MD_XLEN-1:`MD_XLEN];

    // ----------------------------------------
    // Valid bits and stage two
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_s1     <= 1'b0;
            mul_done <= 1'b0;
            result   <= '0;
        end else begin
            v_s1     <= start;
            mul_done <= v_s1;
            if (v_s1)
                result <= prod_word;   // Held until the next op
        end
    end

    assign mul_busy = v_s1 | mul_done;

    // Fixed two-cycle latency
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##2 mul_done);

endmodule

/* verilog/muldiv_unit.sv */
`timescale 1ns/1ns

`include "muldiv_consts.svh"

module muldiv_unit import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  md_op_t              op,
    input  logic [`MD_XLEN-1:0] rs1,
    input  logic [`MD_XLEN-1:0] rs2,
    output logic [`MD_XLEN-1:0] result,
    output logic                done,
    output logic                busy
);

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    logic       sel_div;           // Divider ops have bit 2 set
    logic [1:0] sub_op;

    logic div_start;
    logic mul_start;

    logic [`MD_XLEN-1:0] div_result;
    logic [`MD_XLEN-1:0] mul_result;
    logic                div_done;
    logic                mul_done;
    logic                div_busy;
    logic                mul_busy;

    assign sel_div   = op[2];
    assign sub_op    = op[1:0];
    assign div_start = start & sel_div;
    assign mul_start = start & ~sel_div;

    // ----------------------------------------
    // Units
    // ----------------------------------------
    int_divider u_div (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (div_start),
        .div_op        (sub_op),
        .numerator     (rs1),
        .denominator   (rs2),
        .result        (div_result),
        .division_done (div_done),
        .div_busy      (div_busy)
    );

    int_multiplier u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .mul_op       (sub_op),
        .multiplicand (rs1),
        .multiplier   (rs2),
        .result       (mul_result),
        .mul_done     (mul_done),
        .mul_busy     (mul_busy)
    );

    // ----------------------------------------
    // Result merge
    // ----------------------------------------
    assign result = div_done ? div_result : mul_result;
    assign done   = div_done | mul_done;
    assign busy   = div_busy | mul_busy;   // Caller waits on this

    // Only one op in flight, so completions never collide
    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(div_done && mul_done));

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !start);

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 10;   // 20 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

/* tests/muldiv_tb.sv */
`timescale 1ns/1ns

`include "muldiv_consts.svh"

module muldiv_tb import muldiv_pkg::*; ();

    localparam int MAX_VEC  = 64;
    localparam int NUM_RAND = 24;
    localparam int MUL_LAT  = 2;                   // Falling edges from drive to done
    localparam int DIV_LAT  = `MD_DIV_STEPS + 2;
    localparam int WAIT_MAX = 64;

    logic                clk;
    logic                rst_n;
    logic                start;
    md_op_t              op;
    logic [`MD_XLEN-1:0] rs1;
    logic [`MD_XLEN-1:0] rs2;
    logic [`MD_XLEN-1:0] result;
    logic                done;
    logic                busy;

    // Four words per vector as op, rs1, rs2 and expected
    logic [`MD_XLEN-1:0] vec_mem [0:4*MAX_VEC-1];

    int num_vec;
    int num_checks;
    int num_errors;
    int seed;
    int cycles      = 0;
    int cycle_limit = 2000;   // Replaced once the vectors are counted

    tb_clock_gen u_clk (
        .clk (clk)
    );

    muldiv_unit uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [`MD_XLEN-1:0] expected,
                               input logic [`MD_XLEN-1:0] actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Issue one op on a falling edge, then follow busy and done
    task automatic run_op(input md_op_t op_in, input logic [`MD_XLEN-1:0] a,
                          input logic [`MD_XLEN-1:0] b,
                          input logic [`MD_XLEN-1:0] expected, input string name);
        int lat;
        int exp_lat;
        bit seen;
        seen    = 1'b0;
        exp_lat = op_in[2] ? DIV_LAT : MUL_LAT;
        while (busy)
            @(negedge clk);
        start = 1'b1;
        op    = op_in;
        rs1   = a;
        rs2   = b;
        @(negedge clk);
        start = 1'b0;
        lat   = 1;
        while (!seen && lat <= WAIT_MAX) begin
            check_value({name, " busy"}, `MD_XLEN'(1), `MD_XLEN'(busy));
            if (done) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                lat++;
            end
        end
        if (!seen) begin
            num_errors++;
            $display("%s: done never came within %0d cycles", name, WAIT_MAX);
        end else begin
            check_value({name, " latency"}, `MD_XLEN'(exp_lat), `MD_XLEN'(lat));
            check_value(name, expected, result);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int                    i;
        logic [`MD_XLEN-1:0]   a;
        logic [`MD_XLEN-1:0]   b;
        logic [`MD_XLEN-1:0]   q;
        logic [2*`MD_XLEN-1:0] prod;
        md_op_t                vop;

        rst_n      = 1'b0;
        start      = 1'b0;
        op         = MUL;
        rs1        = '0;
        rs2        = '0;
        seed       = 28896;
        num_checks = 0;
        num_errors = 0;

        $readmemh("tests/muldiv_testdata.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[4*num_vec] != `MD_XLEN'('hff))
            num_vec++;                                // Op ff ends the list
        cycle_limit = (num_vec + NUM_RAND) * 40 + 200;
        if (num_vec == 0) begin
            num_errors++;
            $display("No vectors found in tests/muldiv_testdata.txt");
        end

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        check_value("reset done", '0, `MD_XLEN'(done));
        check_value("reset busy", '0, `MD_XLEN'(busy));
        check_value("reset result", '0, result);

        for (i = 0; i < num_vec; i++) begin
            vop = md_op_t'(vec_mem[4*i][3:0]);
            run_op(vop, vec_mem[4*i+1], vec_mem[4*i+2], vec_mem[4*i+3],
                   $sformatf("vector %0d %s", i, vop.name()));
        end

        // Random phase alternating MUL and DIVU
        for (i = 0; i < NUM_RAND; i++) begin
            a = $random(seed);
            b = $random(seed);
            if (i % 2 == 0) begin
                prod = {{`MD_XLEN{1'b0}}, a} * {{`MD_XLEN{1'b0}}, b};
                run_op(MUL, a, b, prod[`MD_XLEN-1:0], $sformatf("random %0d MUL", i));
            end else begin
                b = b >> a[4:0];        // Spread divisor sizes
                if (i == 9)
                    b = '0;
                q = (b == '0) ? '1 : a / b;
                run_op(DIVU, a, b, q, $sformatf("random %0d DIVU", i));
            end
        end

        $display("Summary: %0d vectors, %0d random ops, %0d checks, %0d errors",
                 num_vec, NUM_RAND, num_checks, num_errors);
        if (num_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* muldiv_unit.f */
+incdir+verilog
verilog/muldiv_pkg.sv
verilog/int_divider.sv
verilog/int_multiplier.sv
verilog/muldiv_unit.sv
tests/tb_clock_gen.sv
tests/muldiv_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the muldiv_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f muldiv_unit.f --top-module muldiv_tb -o muldiv_sim \
    && ./obj_dir/muldiv_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error status"

cat sim.log 2>/dev/null

grep -q "^TEST PASS$" sim.log && exit 0 || exit 1

/* tests/muldiv_testdata.txt */
// Columns: op rs1 rs2 expected, all hex
// Op codes 0-3 MUL MULH MULHSU MULHU, 4-7 DIV DIVU REM REMU, ff ends the list
0 00000007 00000006 0000002a
0 ffffffff ffffffff 00000001
0 80000000 ffffffff 80000000
0 12345678 00000010 23456780
0 fffffffe 00000003 fffffffa
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 80000000 ffffffff 00000000
1 ffffffff 00000002 ffffffff
1 7fffffff 7fffffff 3fffffff
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 00000002 ffffffff 00000001
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 00010000 00010000 00000001
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 00000005 00000000 ffffffff
4 80000000 ffffffff 80000000
5 00000014 00000006 00000003
5 ffffffec 00000006 2aaaaaa7
5 00000007 00000000 ffffffff
5 80000000 ffffffff 00000000
6 00000014 00000006 00000002
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
6 00000005 00000000 00000005
6 80000000 ffffffff 00000000
7 ffffffec 00000006 00000002
7 00000009 00000000 00000009
ff 00000000 00000000 00000000
